//--- source/core_arch_pkg.sv
// Core architecture package
// Data width and word type shared by the execute stage units

package core_arch_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int XLEN      = 64;  // Register width
    localparam int WORD_BITS = 32;  // Width of the W-suffixed operations

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    // One register-sized data word, operands and results
    typedef logic [XLEN-1:0] xword_t;

endpackage

//--- source/mdu_pkg.sv
// Multiply-divide unit package
// Opcodes, sequencer states, counter width and the request bundle

package mdu_pkg;

    // Enough for a count of 64
    localparam int CTR_W = 7;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------

    // Bit 2 set selects the divider
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } mdu_op_e;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } mdu_state_e;

    // ------------------------------------------------------------------------
    // Request, held stable by the issuer for the whole operation
    // ------------------------------------------------------------------------

    typedef struct packed {
        mdu_op_e               op;
        logic                  word;  // 32-bit form, result sign-extended
        core_arch_pkg::xword_t rs1;
        core_arch_pkg::xword_t rs2;
    } mdu_req_t;

endpackage

//--- source/mdu_seq.sv
`timescale 1ns/10ps
// Multiply-divide sequencer
// Detects a new request, runs the iteration counter for the selected
// datapath and holds the result until flush

module mdu_seq #(
    parameter int MUL_UNROLL = 4
) (
    input  logic                       g_clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       valid,
    input  mdu_pkg::mdu_op_e           op,
    input  logic                       word,
    input  core_arch_pkg::xword_t      mul_result,
    input  core_arch_pkg::xword_t      div_result,
    output logic                       start,
    output logic                       run,
    output logic [mdu_pkg::CTR_W-1:0]  ctr,
    output logic                       ready,
    output core_arch_pkg::xword_t      rd
);

    localparam int CW = mdu_pkg::CTR_W;

    // Odd unroll stops one short of zero
    localparam logic [CW-1:0] MUL_END = (MUL_UNROLL % 2 == 0) ? CW'(0) : CW'(1);

    mdu_pkg::mdu_state_e state;

    logic          is_div;
    logic [CW-1:0] ctr_end;
    logic [CW-1:0] ctr_step;

    assign is_div   = op[2];                            // Divider class
    assign ctr_end  = is_div ? CW'(0) : MUL_END;
    assign ctr_step = is_div ? CW'(1) : CW'(MUL_UNROLL);

    assign start = valid && (state == mdu_pkg::IDLE);
    assign run   = (state == mdu_pkg::RUN);
    assign ready = (state == mdu_pkg::DONE);
    assign rd    = is_div ? div_result : mul_result;

    // ------------------------------------------------------------------------
    // State and iteration counter
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            state <= mdu_pkg::IDLE;
            ctr   <= '0;
        end else begin
            case (state)
                mdu_pkg::IDLE: begin
                    if (start) begin
                        state <= mdu_pkg::RUN;
                        ctr   <= word ? CW'(core_arch_pkg::WORD_BITS)
                                      : CW'(core_arch_pkg::XLEN);
                    end
                end
                mdu_pkg::RUN: begin
                    if (ctr == ctr_end) begin
                        state <= mdu_pkg::DONE;     // Datapath idle from here
                    end else begin
                        ctr <= ctr - ctr_step;
                    end
                end
                mdu_pkg::DONE: state <= mdu_pkg::DONE;  // Held until flush
                default:       state <= mdu_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- source/mdu_mul_iter.sv
`timescale 1ns/10ps
// Iterative shift-add multiplier
// Consumes MUL_UNROLL multiplier bits per cycle into a double-width
// accumulator that shifts right, so the full product ends up in place

module mdu_mul_iter #(
    parameter int MUL_UNROLL = 4
) (
    input  logic                       g_clk,
    input  logic                       start,
    input  logic                       run,
    input  logic [mdu_pkg::CTR_W-1:0]  ctr,
    input  mdu_pkg::mdu_req_t          req,
    output core_arch_pkg::xword_t      result
);

    localparam int XLEN = core_arch_pkg::XLEN;
    localparam int WB   = core_arch_pkg::WORD_BITS;
    localparam int CW   = mdu_pkg::CTR_W;

    core_arch_pkg::xword_t mcand;       // Multiplicand, fixed for the op
    core_arch_pkg::xword_t mplier;      // Multiplier, bit 0 consumed first
    logic [2*XLEN-1:0]     acc;
    logic [2*XLEN-1:0]     acc_nxt;

    logic rs1_signed;
    logic rs2_signed;
    logic mul_hi;
    logic step;

    assign rs1_signed = (req.op == mdu_pkg::MULH) || (req.op == mdu_pkg::MULHSU);
    assign rs2_signed = (req.op == mdu_pkg::MULH);
    assign mul_hi     = (req.op == mdu_pkg::MULH) || (req.op == mdu_pkg::MULHSU) ||
                        (req.op == mdu_pkg::MULHU);
    assign step       = run && (ctr != '0);

    // ------------------------------------------------------------------------
    // One cycle of partial products
    // ------------------------------------------------------------------------

    always_comb begin
        logic [XLEN:0] add_l;
        logic [XLEN:0] add_r;
        logic [XLEN:0] sum;
        logic          sub_last;
        acc_nxt = acc;
        for (int i = 0; i < MUL_UNROLL; i++) begin
            // Top bit of a signed multiplier weighs -2^63
            sub_last = (i == MUL_UNROLL - 1) && (ctr == CW'(MUL_UNROLL)) &&
                       rs2_signed && mplier[i];
            add_l    = {rs1_signed & acc_nxt[2*XLEN-1], acc_nxt[2*XLEN-1:XLEN]};
            add_r    = mplier[i] ? {rs1_signed & mcand[XLEN-1], mcand} : '0;
            if (sub_last) begin
                add_r = ~add_r;                 // Two's complement with carry in
            end
            sum      = add_l + add_r + {{XLEN{1'b0}}, sub_last};
            acc_nxt  = {sum, acc_nxt[XLEN-1:1]};
        end
    end

    // Operand and accumulator registers, no reset needed
    always_ff @(posedge g_clk) begin
        if (start) begin
            mcand  <= req.rs1;
            mplier <= req.rs2;
            acc    <= '0;
        end else if (step) begin
            mplier <= mplier >> MUL_UNROLL;
            acc    <= acc_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------

    // After 32 steps the low product word sits just under the top half.
    // Word mode returns that word for every multiply opcode
    always_comb begin
        if (req.word) begin
            result = {{(XLEN-WB){acc[XLEN-1]}}, acc[XLEN-1 -: WB]};
        end else if (mul_hi) begin
            result = acc[2*XLEN-1:XLEN];
        end else begin
            result = acc[XLEN-1:0];
        end
    end

endmodule

//--- source/mdu_div_iter.sv
`timescale 1ns/10ps
// Iterative restoring divider
// Works on operand magnitudes, one quotient bit per cycle, and applies
// the RISC-V sign rules to the quotient or remainder on the way out

module mdu_div_iter (
    input  logic                       g_clk,
    input  logic                       start,
    input  logic                       run,
    input  logic [mdu_pkg::CTR_W-1:0]  ctr,
    input  mdu_pkg::mdu_req_t          req,
    output core_arch_pkg::xword_t      result
);

    localparam int XLEN = core_arch_pkg::XLEN;
    localparam int WB   = core_arch_pkg::WORD_BITS;

    core_arch_pkg::xword_t dividend;    // Partial remainder
    core_arch_pkg::xword_t quotient;
    logic [2*XLEN-1:0]     divisor;     // Shifted divisor, moves right

    core_arch_pkg::xword_t rs1_ext;
    core_arch_pkg::xword_t rs2_ext;
    core_arch_pkg::xword_t rs1_abs;
    core_arch_pkg::xword_t rs2_abs;
    core_arch_pkg::xword_t qmask;
    core_arch_pkg::xword_t pre_sext;
    logic [2*XLEN-1:0]     divisor_init;

    logic signed_op;
    logic div_q;                        // Quotient wanted, else remainder
    logic sign_lhs;
    logic sign_rhs;
    logic rs2_nz;
    logic out_neg;
    logic fits;
    logic step;

    // ------------------------------------------------------------------------
    // Operand preparation
    // ------------------------------------------------------------------------

    assign signed_op = (req.op == mdu_pkg::DIV) || (req.op == mdu_pkg::REM);
    assign div_q     = (req.op == mdu_pkg::DIV) || (req.op == mdu_pkg::DIVU);

    // Word operands extended by the op's signedness
    assign rs1_ext = req.word ? {{(XLEN-WB){signed_op & req.rs1[WB-1]}}, req.rs1[WB-1:0]}
                              : req.rs1;
    assign rs2_ext = req.word ? {{(XLEN-WB){signed_op & req.rs2[WB-1]}}, req.rs2[WB-1:0]}
                              : req.rs2;

    assign sign_lhs = signed_op && rs1_ext[XLEN-1];
    assign sign_rhs = signed_op && rs2_ext[XLEN-1];
    assign rs2_nz   = |rs2_ext;

    // Most negative value maps to its unsigned magnitude
    assign rs1_abs = sign_lhs ? -rs1_ext : rs1_ext;
    assign rs2_abs = sign_rhs ? -rs2_ext : rs2_ext;

    // Align divisor with the top quotient bit
    assign divisor_init = {{XLEN{1'b0}}, rs2_abs} << (req.word ? (WB - 1) : (XLEN - 1));

    // ------------------------------------------------------------------------
    // Iteration
    // ------------------------------------------------------------------------

    assign step  = run && (ctr != '0);
    assign fits  = divisor <= {{XLEN{1'b0}}, dividend};
    assign qmask = {{(XLEN-1){1'b0}}, 1'b1} << (ctr - 1'b1);

    always_ff @(posedge g_clk) begin
        if (start) begin
            dividend <= rs1_abs;
            divisor  <= divisor_init;
            quotient <= '0;
        end else if (step) begin
            if (fits) begin
                dividend <= dividend - divisor[XLEN-1:0];
                quotient <= quotient | qmask;
            end
            divisor <= divisor >> 1;
        end
    end

    // ------------------------------------------------------------------------
    // Output sign and width
    // ------------------------------------------------------------------------

    // Zero divisor keeps the quotient at all ones and the remainder at rs1
    assign out_neg  = div_q ? ((sign_lhs ^ sign_rhs) && rs2_nz) : sign_lhs;
    assign pre_sext = div_q ? (out_neg ? -quotient : quotient)
                            : (out_neg ? -dividend : dividend);

    assign result = req.word ? {{(XLEN-WB){pre_sext[WB-1]}}, pre_sext[WB-1:0]}
                             : pre_sext;

endmodule

//--- source/core_pipe_exec_mdu.sv
`timescale 1ns/10ps
// Execute stage multiply-divide unit
// Sequencer plus separate multiplier and divider datapaths, one
// operation at a time, result held with ready until flush

module core_pipe_exec_mdu #(
    parameter int MUL_UNROLL = 4    // 1, 2, 4 or 8
) (
    input  logic                   g_clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   valid,
    input  mdu_pkg::mdu_req_t      req,
    output logic                   ready,
    output core_arch_pkg::xword_t  rd
);

    logic                       start;
    logic                       run;
    logic [mdu_pkg::CTR_W-1:0]  ctr;
    core_arch_pkg::xword_t      mul_result;
    core_arch_pkg::xword_t      div_result;

    mdu_seq #(
        .MUL_UNROLL (MUL_UNROLL)
    ) u_seq (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .valid      (valid),
        .op         (req.op),
        .word       (req.word),
        .mul_result (mul_result),
        .div_result (div_result),
        .start      (start),
        .run        (run),
        .ctr        (ctr),
        .ready      (ready),
        .rd         (rd)
    );

    mdu_mul_iter #(
        .MUL_UNROLL (MUL_UNROLL)
    ) u_mul (
        .g_clk  (g_clk),
        .start  (start),
        .run    (run),
        .ctr    (ctr),
        .req    (req),
        .result (mul_result)
    );

    mdu_div_iter u_div (
        .g_clk  (g_clk),
        .start  (start),
        .run    (run),
        .ctr    (ctr),
        .req    (req),
        .result (div_result)
    );

endmodule

//--- dv/mdu_checker.sv
`timescale 1ns/10ps
// Sequencer control checker
// Concurrent assertions on state, ready, run and the iteration counter

module mdu_checker (
    input logic                      g_clk,
    input logic                      rst_n,
    input logic                      flush,
    input mdu_pkg::mdu_state_e       state,
    input logic                      run,
    input logic                      ready,
    input logic [mdu_pkg::CTR_W-1:0] ctr
);

    int unsigned violations = 0;    // Failed assertion count

    ready_only_in_done: assert property (@(posedge g_clk) disable iff (!rst_n)
        ready |-> state == mdu_pkg::DONE)
        else begin
            $error("ready high outside the DONE state");
            violations++;
        end

    ready_low_after_flush: assert property (@(posedge g_clk) disable iff (!rst_n)
        flush |=> !ready)
        else begin
            $error("ready high in the cycle after flush");
            violations++;
        end

    run_ready_exclusive: assert property (@(posedge g_clk) disable iff (!rst_n)
        !(run && ready))
        else begin
            $error("run and ready high together");
            violations++;
        end

    ctr_in_range: assert property (@(posedge g_clk) disable iff (!rst_n)
        ctr <= mdu_pkg::CTR_W'(core_arch_pkg::XLEN))
        else begin
            $error("iteration counter above 64");
            violations++;
        end

endmodule

bind mdu_seq mdu_checker u_chk (
    .g_clk (g_clk),
    .rst_n (rst_n),
    .flush (flush),
    .state (state),
    .run   (run),
    .ready (ready),
    .ctr   (ctr)
);

//--- dv/mdu_ref_model.svh
// Reference model for the multiply-divide unit
// Expected rd of any request, from the RISC-V rules on wide arithmetic

`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// Full 128-bit product of the extended operands
function automatic core_arch_pkg::xword_t mul_expect(mdu_pkg::mdu_op_e op, logic word,
                                                     core_arch_pkg::xword_t a,
                                                     core_arch_pkg::xword_t b);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] prod;
    ea = {64'b0, a};
    eb = {64'b0, b};
    if (op == mdu_pkg::MULH || op == mdu_pkg::MULHSU) ea = {{64{a[63]}}, a};
    if (op == mdu_pkg::MULH) eb = {{64{b[63]}}, b};
    prod = ea * eb;
    if (word) return {{32{prod[31]}}, prod[31:0]};   // Only MULW exists in word form
    if (op == mdu_pkg::MUL) return prod[63:0];
    return prod[127:64];
endfunction

function automatic core_arch_pkg::xword_t div_expect(mdu_pkg::mdu_op_e op, logic word,
                                                     core_arch_pkg::xword_t a,
                                                     core_arch_pkg::xword_t b);
    logic        sgn;
    logic        want_q;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] q;
    logic [63:0] r;
    logic [63:0] res;
    sgn    = (op == mdu_pkg::DIV) || (op == mdu_pkg::REM);
    want_q = (op == mdu_pkg::DIV) || (op == mdu_pkg::DIVU);
    x = word ? {{32{sgn & a[31]}}, a[31:0]} : a;
    y = word ? {{32{sgn & b[31]}}, b[31:0]} : b;
    if (y == 64'd0) begin
        q = '1;                                  // Divide by zero
        r = x;
    end else if (sgn && x == 64'h8000_0000_0000_0000 && y == '1) begin
        q = x;                                   // Signed overflow
        r = 64'd0;
    end else if (sgn) begin
        q = $signed(x) / $signed(y);
        r = $signed(x) % $signed(y);
    end else begin
        q = x / y;
        r = x % y;
    end
    res = want_q ? q : r;
    if (word) res = {{32{res[31]}}, res[31:0]};
    return res;
endfunction

function automatic core_arch_pkg::xword_t expect_result(mdu_pkg::mdu_op_e op, logic word,
                                                        core_arch_pkg::xword_t a,
                                                        core_arch_pkg::xword_t b);
    return op[2] ? div_expect(op, word, a, b) : mul_expect(op, word, a, b);
endfunction

`endif

//--- dv/tb_core_pipe_exec_mdu.sv
`timescale 1ns/10ps
// Testbench for the multiply-divide unit
// LCG driven operations checked against a reference model, plus
// divider corner cases and flush aborts

module tb_core_pipe_exec_mdu;

    `include "mdu_ref_model.svh"

    localparam int N_RAND      = 200;
    localparam int N_CORNER    = 16;
    localparam int N_ABORT     = 20;
    localparam int TOTAL_OPS   = 4 * N_RAND + N_CORNER + 2 * N_ABORT;
    localparam int CYCLE_LIMIT = 80 * TOTAL_OPS;
    localparam int READY_WAIT  = 70;

    logic                  g_clk;
    logic                  rst_n;
    logic                  flush;
    logic                  valid;
    mdu_pkg::mdu_req_t     req;
    logic                  ready;
    core_arch_pkg::xword_t rd;

    logic [63:0] lcg_state;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          cycle_count;

    core_pipe_exec_mdu #(.MUL_UNROLL(4)) u_dut (
        .g_clk (g_clk),
        .rst_n (rst_n),
        .flush (flush),
        .valid (valid),
        .req   (req),
        .ready (ready),
        .rd    (rd)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge g_clk);
            cycle_count++;
        end
        $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Random numbers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    function automatic core_arch_pkg::xword_t rand_word();
        return {next_rand(), next_rand()};
    endfunction

    // Extreme signs mixed with plain random words
    function automatic core_arch_pkg::xword_t biased_word();
        logic [31:0] sel;
        sel = next_rand();
        case (sel[1:0])
            2'd0:    return rand_word();
            2'd1:    return rand_word() | 64'h8000_0000_0000_0000;
            2'd2:    return 64'h7FFF_FFFF_FFFF_FFFF ^ {52'b0, sel[13:2]};
            default: return {52'hF_FFFF_FFFF_FFFF, sel[13:2]};   // Small negative
        endcase
    endfunction

    // Small divisors of either sign, or a wide one
    function automatic core_arch_pkg::xword_t divisor_word();
        logic [31:0] sel;
        sel = next_rand();
        if (sel[1:0] == 2'd0) return {56'b0, sel[15:8]};
        if (sel[1:0] == 2'd1) return -{56'b0, sel[15:8]};
        return rand_word() >> sel[7:2];
    endfunction

    // ------------------------------------------------------------------------
    // Driving and checking
    // ------------------------------------------------------------------------

    task automatic issue_req(input mdu_pkg::mdu_op_e op, input logic word,
                             input core_arch_pkg::xword_t a, input core_arch_pkg::xword_t b);
        mdu_pkg::mdu_req_t r;
        r.op   = op;
        r.word = word;
        r.rs1  = a;
        r.rs2  = b;
        @(posedge g_clk);
        req   <= r;
        valid <= 1'b1;
    endtask

    task automatic flush_unit();
        @(posedge g_clk);
        valid <= 1'b0;
        flush <= 1'b1;
        @(posedge g_clk);
        flush <= 1'b0;
    endtask

    task automatic check_idle(input string name);
        @(negedge g_clk);
        test_checks++;
        assert (!ready) else begin
            $display("%s: ready went high while the operation was aborted", name);
            test_errors++;
        end
    endtask

    task automatic run_op(input string name, input mdu_pkg::mdu_op_e op, input logic word,
                          input core_arch_pkg::xword_t a, input core_arch_pkg::xword_t b);
        core_arch_pkg::xword_t exp;
        int                    waited;
        exp = expect_result(op, word, a, b);
        issue_req(op, word, a, b);
        waited = 0;
        @(negedge g_clk);
        while (!ready && waited < READY_WAIT) begin
            @(negedge g_clk);
            waited++;
        end
        test_checks++;
        assert (ready) else begin
            $display("%s: %s never raised ready within %0d cycles", name, op.name(), READY_WAIT);
            test_errors++;
        end
        if (ready) begin
            assert (rd == exp) else begin
                $display("ERROR %s: %s word=%0b rs1=%h rs2=%h expected %h actual %h",
                         name, op.name(), word, a, b, exp, rd);
                test_errors++;
            end
        end
        flush_unit();
    endtask

    task automatic begin_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        checks += test_checks;
        errors += test_errors;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    initial begin
        mdu_pkg::mdu_op_e op;
        logic [31:0]      r;
        int               n;
        lcg_state = 64'd26352;
        rst_n  = 1'b0;
        flush  = 1'b0;
        valid  = 1'b0;
        req    = '0;
        checks = 0;
        errors = 0;
        repeat (3) @(posedge g_clk);
        rst_n <= 1'b1;

        begin_test();
        repeat (N_RAND) run_op("mul_low", mdu_pkg::MUL, 1'b0, rand_word(), rand_word());
        end_test("mul_low");

        begin_test();
        repeat (N_RAND) begin
            r  = next_rand();
            op = mdu_pkg::mdu_op_e'(3'(1 + r % 3));     // MULH, MULHSU or MULHU
            run_op("mul_high", op, 1'b0, biased_word(), biased_word());
        end
        end_test("mul_high");

        begin_test();
        repeat (N_RAND) begin
            r  = next_rand();
            op = mdu_pkg::mdu_op_e'({1'b1, r[1:0]});
            run_op("div_rem", op, 1'b0, rand_word(), divisor_word());
        end
        end_test("div_rem");

        begin_test();
        repeat (N_RAND) begin
            r  = next_rand();
            op = mdu_pkg::mdu_op_e'(r[2:0]);
            run_op("word_ops", op, 1'b1, rand_word(), r[3] ? divisor_word() : rand_word());
        end
        end_test("word_ops");

        // Zero divisor, then most negative over -1; upper halves are noise in word mode
        begin_test();
        for (int w = 0; w < 2; w++) begin
            for (int k = 4; k < 8; k++) begin
                op = mdu_pkg::mdu_op_e'(3'(k));
                run_op("div_corner", op, w[0], rand_word(),
                       w[0] ? {next_rand(), 32'h0} : 64'h0);
                run_op("div_corner", op, w[0],
                       w[0] ? {next_rand(), 32'h8000_0000} : 64'h8000_0000_0000_0000,
                       w[0] ? {next_rand(), 32'hFFFF_FFFF} : 64'hFFFF_FFFF_FFFF_FFFF);
            end
        end
        end_test("div_corner");

        // 64-bit divides outlast the abort window
        begin_test();
        repeat (N_ABORT) begin
            r = next_rand();
            n = 1 + r % 30;
            issue_req(mdu_pkg::mdu_op_e'({1'b1, r[1:0]}), 1'b0, rand_word(), divisor_word());
            repeat (n) check_idle("flush_abort");
            flush_unit();
            // Past the point where the aborted divide would have finished
            repeat (READY_WAIT - n) check_idle("flush_abort");
            run_op("flush_abort", mdu_pkg::mdu_op_e'(r[7:5]), r[8], rand_word(), divisor_word());
        end
        end_test("flush_abort");

        $display("Summary: %0d checks, %0d errors, %0d checker failures",
                 checks, errors, u_dut.u_seq.u_chk.violations);
        if (errors == 0 && u_dut.u_seq.u_chk.violations == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- core_pipe_exec_mdu.f
+incdir+dv
source/core_arch_pkg.sv
source/mdu_pkg.sv
source/mdu_seq.sv
source/mdu_mul_iter.sv
source/mdu_div_iter.sv
source/core_pipe_exec_mdu.sv
dv/mdu_checker.sv
dv/tb_core_pipe_exec_mdu.sv

//--- Bender.yml
package:
  name: core_pipe_exec_mdu

sources:
  # RTL, packages first
  - target: any(rtl, test)
    files:
      - source/core_arch_pkg.sv
      - source/mdu_pkg.sv
      - source/mdu_seq.sv
      - source/mdu_mul_iter.sv
      - source/mdu_div_iter.sv
      - source/core_pipe_exec_mdu.sv
  # Testbench and bound checker
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mdu_checker.sv
      - dv/tb_core_pipe_exec_mdu.sv
